// ==== build.f ====
hw/spike_gen_pkg.sv
hw/spike_gen_mem.sv
hw/spike_fifo.sv
hw/time_unit_timer.sv
hw/spike_gen_array.sv
hw/spike_gen_top.sv
testbench/spike_gen_asserts.sv
testbench/spike_gen_tb.sv

// ==== hw/spike_fifo.sv ====
`timescale 1ns/10ps

module spike_fifo #(
  parameter type payload_t = logic
) (
  input logic clk,
  input logic reset,
  input logic in_valid,
  output logic in_ready,
  input payload_t in_data,
  output logic out_valid,
  input logic out_ready,
  output payload_t out_data
);
  import spike_gen_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int cnt_w = $clog2(fifo_depth + 1);

  payload_t buf_q [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic push;
  logic pop;
  logic full;

  assign full = (count == cnt_w'(fifo_depth));
  // a pop frees a slot in the same cycle
  assign in_ready = ~full | out_ready;
  assign out_valid = (count != '0);
  // head entry straight from storage
  assign out_data = buf_q[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop = out_valid & out_ready;

  // storage, no reset
  always_ff @(posedge clk) begin
    if (push) begin
      buf_q[wr_ptr] <= in_data;
    end
  end

  ////////////////////////////////////////
  // pointers and occupancy

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        // wrap at the last slot
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hw/spike_gen_array.sv ====
`timescale 1ns/10ps

module spike_gen_array (
  input logic clk,
  input logic reset,
  input logic unit_pulse,
  input logic [spike_gen_pkg::gens_used_w-1:0] gens_used,
  input logic [spike_gen_pkg::n_gens-1:0] gens_en,
  input logic prog_valid,
  output logic prog_ready,
  input spike_gen_pkg::prog_entry_t prog_entry,
  output logic out_valid,
  input logic out_ready,
  output spike_gen_pkg::spike_event_t out_event,
  output logic overrun
);
  import spike_gen_pkg::*;

  ////////////////////////////////////////
  // generator state memory

  logic mem_wr_en;
  gen_idx_t mem_wr_addr;
  gen_word_t mem_wr_data;
  logic mem_rd_en;
  gen_word_t mem_rd_data;
  // current generator, also the read address
  gen_idx_t gen_idx;

  spike_gen_mem u_mem (
    .clk(clk),
    .wr_en(mem_wr_en),
    .wr_addr(mem_wr_addr),
    .wr_data(mem_wr_data),
    .rd_en(mem_rd_en),
    .rd_addr(gen_idx),
    .rd_data(mem_rd_data)
  );

  ////////////////////////////////////////
  // sequencer

  // idle also takes programming writes
  typedef enum logic [1:0] {s_idle, s_read, s_wait, s_writeback} state_t;
  state_t state;
  state_t next_state;
  gen_idx_t next_gen_idx;

  logic [gens_used_w-1:0] gen_idx_ext;
  logic [gens_used_w-1:0] gen_idx_p1;
  logic gen_active;
  logic more_gens;
  logic stall_out;
  logic prog_fire;

  // single incrementer, shared by index advance and end check
  assign gen_idx_ext = gens_used_w'(gen_idx);
  assign gen_idx_p1 = gen_idx_ext + 1'b1;
  assign more_gens = (gen_idx_p1 < gens_used);
  // index check also covers gens_used of zero
  assign gen_active = gens_en[gen_idx] & (gen_idx_ext < gens_used);
  assign stall_out = out_valid & ~out_ready;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= s_idle;
      gen_idx <= '0;
    end else begin
      state <= next_state;
      gen_idx <= next_gen_idx;
    end
  end

  always_comb begin
    next_state = state;
    next_gen_idx = gen_idx;
    unique case (state)
      s_idle: begin
        // walk always starts at generator 0
        next_gen_idx = '0;
        if (unit_pulse) begin
          next_state = s_read;
        end
      end
      s_read: begin
        if (gen_active) begin
          // read issued this cycle
          next_state = s_wait;
        end else if (more_gens) begin
          // disabled, skip in one cycle
          next_gen_idx = gen_idx_t'(gen_idx_p1);
        end else begin
          next_state = s_idle;
        end
      end
      s_wait: begin
        // read word lands in the memory output register
        next_state = s_writeback;
      end
      s_writeback: begin
        // a stalled spike keeps us here, the write simply repeats
        if (!stall_out) begin
          if (more_gens) begin
            next_state = s_read;
            next_gen_idx = gen_idx_t'(gen_idx_p1);
          end else begin
            next_state = s_idle;
          end
        end
      end
      default: begin
        next_state = s_idle;
      end
    endcase
  end

  ////////////////////////////////////////
  // writeback datapath

  period_t wr_tick;
  logic emit;

  // below the period count up, otherwise wrap to 1 and fire
  always_comb begin
    if (mem_rd_data.ticks < mem_rd_data.period) begin
      wr_tick = mem_rd_data.ticks + 1'b1;
      emit = 1'b0;
    end else begin
      wr_tick = period_t'(1);
      emit = 1'b1;
    end
  end

  ////////////////////////////////////////
  // memory ports and programming

  // pulse wins over programming in idle
  assign prog_ready = (state == s_idle) & ~unit_pulse;
  assign prog_fire = prog_valid & prog_ready;

  assign mem_rd_en = (state == s_read) & gen_active;
  assign mem_wr_en = (state == s_writeback) | prog_fire;

  always_comb begin
    if (state == s_writeback) begin
      mem_wr_addr = gen_idx;
      mem_wr_data.ticks = wr_tick;
      mem_wr_data.period = mem_rd_data.period;
      mem_wr_data.tag = mem_rd_data.tag;
    end else begin
      // programming write
      mem_wr_addr = prog_entry.gen_idx;
      mem_wr_data.ticks = prog_entry.ticks;
      mem_wr_data.period = prog_entry.period;
      mem_wr_data.tag = prog_entry.tag;
    end
  end

  ////////////////////////////////////////
  // spike output

  assign out_valid = (state == s_writeback) & emit;
  // held stable through a stall, read register does not change
  assign out_event.tag = mem_rd_data.tag;
  assign out_event.ct = ct_t'(1);

  // sticky, a pulse while busy means the walk was too slow
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      overrun <= 1'b0;
    end else if (unit_pulse && state != s_idle) begin
      overrun <= 1'b1;
    end
  end

endmodule

// ==== hw/spike_gen_mem.sv ====
`timescale 1ns/10ps

module spike_gen_mem (
  input logic clk,
  input logic wr_en,
  input spike_gen_pkg::gen_idx_t wr_addr,
  input spike_gen_pkg::gen_word_t wr_data,
  input logic rd_en,
  input spike_gen_pkg::gen_idx_t rd_addr,
  output spike_gen_pkg::gen_word_t rd_data
);
  import spike_gen_pkg::*;

  // one word per generator
  gen_word_t mem [n_gens];

  // synchronous write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, value holds while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== hw/spike_gen_pkg.sv ====
package spike_gen_pkg;

  ////////////////////////////////////////
  // sizes

  // generators in the array
  localparam int n_gens = 8;
  localparam int gen_idx_w = 3;
  // gens_used counts up to n_gens inclusive
  localparam int gens_used_w = 4;
  localparam int period_w = 16;
  localparam int tag_w = 11;
  localparam int ct_w = 10;
  localparam int unit_len_w = 16;
  // both fifos share this depth
  localparam int fifo_depth = 4;

  ////////////////////////////////////////
  // field types

  typedef logic [gen_idx_w-1:0] gen_idx_t;
  typedef logic [period_w-1:0] period_t;
  typedef logic [tag_w-1:0] tag_t;
  typedef logic [ct_w-1:0] ct_t;

  ////////////////////////////////////////
  // words and payloads

  // one memory word per generator, ticks is time units since last wrap
  typedef struct packed {
    period_t ticks;
    period_t period;
    tag_t tag;
  } gen_word_t;

  // programming entry, overwrites a whole generator word
  typedef struct packed {
    gen_idx_t gen_idx;
    period_t ticks;
    period_t period;
    tag_t tag;
  } prog_entry_t;

  // spike event on the output
  typedef struct packed {
    tag_t tag;
    ct_t ct;
  } spike_event_t;

endpackage

// ==== hw/spike_gen_top.sv ====
`timescale 1ns/10ps

module spike_gen_top (
  input logic clk,
  input logic reset,
  input logic run,
  input logic [spike_gen_pkg::unit_len_w-1:0] unit_len,
  input logic [spike_gen_pkg::gens_used_w-1:0] gens_used,
  input logic [spike_gen_pkg::n_gens-1:0] gens_en,
  input logic prog_valid,
  output logic prog_ready,
  input spike_gen_pkg::gen_idx_t prog_gen_idx,
  input spike_gen_pkg::period_t prog_ticks,
  input spike_gen_pkg::period_t prog_period,
  input spike_gen_pkg::tag_t prog_tag,
  output logic spike_valid,
  input logic spike_ready,
  output spike_gen_pkg::tag_t spike_tag,
  output spike_gen_pkg::ct_t spike_ct,
  output logic unit_pulse,
  output logic overrun
);
  import spike_gen_pkg::*;

  prog_entry_t prog_in;
  prog_entry_t prog_out;
  logic prog_out_valid;
  logic prog_out_ready;
  spike_event_t event_in;
  spike_event_t event_out;
  logic event_in_valid;
  logic event_in_ready;

  // pack the loose programming fields
  assign prog_in.gen_idx = prog_gen_idx;
  assign prog_in.ticks = prog_ticks;
  assign prog_in.period = prog_period;
  assign prog_in.tag = prog_tag;

  ////////////////////////////////////////
  // time base

  time_unit_timer u_timer (
    .clk(clk),
    .reset(reset),
    .run(run),
    .unit_len(unit_len),
    .unit_pulse(unit_pulse)
  );

  ////////////////////////////////////////
  // programming path

  spike_fifo #(.payload_t(prog_entry_t)) prog_fifo (
    .clk(clk),
    .reset(reset),
    .in_valid(prog_valid),
    .in_ready(prog_ready),
    .in_data(prog_in),
    .out_valid(prog_out_valid),
    .out_ready(prog_out_ready),
    .out_data(prog_out)
  );

  spike_gen_array u_array (
    .clk(clk),
    .reset(reset),
    .unit_pulse(unit_pulse),
    .gens_used(gens_used),
    .gens_en(gens_en),
    .prog_valid(prog_out_valid),
    .prog_ready(prog_out_ready),
    .prog_entry(prog_out),
    .out_valid(event_in_valid),
    .out_ready(event_in_ready),
    .out_event(event_in),
    .overrun(overrun)
  );

  ////////////////////////////////////////
  // spike output path

  spike_fifo #(.payload_t(spike_event_t)) spike_out_fifo (
    .clk(clk),
    .reset(reset),
    .in_valid(event_in_valid),
    .in_ready(event_in_ready),
    .in_data(event_in),
    .out_valid(spike_valid),
    .out_ready(spike_ready),
    .out_data(event_out)
  );

  // unpack onto the loose output fields
  assign spike_tag = event_out.tag;
  assign spike_ct = event_out.ct;

endmodule

// ==== hw/time_unit_timer.sv ====
`timescale 1ns/10ps

module time_unit_timer (
  input logic clk,
  input logic reset,
  input logic run,
  input logic [spike_gen_pkg::unit_len_w-1:0] unit_len,
  output logic unit_pulse
);

  logic [$bits(unit_len)-1:0] count;
  logic [$bits(unit_len)-1:0] last_count;

  // terminal count of one time unit
  assign last_count = unit_len - 1'b1;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      count <= '0;
      unit_pulse <= 1'b0;
    end else if (!run) begin
      // stopped, hold the counter cleared
      count <= '0;
      unit_pulse <= 1'b0;
    end else if (count == last_count) begin
      // end of unit, pulse for one cycle and restart
      count <= '0;
      unit_pulse <= 1'b1;
    end else begin
      count <= count + 1'b1;
      unit_pulse <= 1'b0;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the spike generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module spike_gen_tb -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# raise the error limit so assertion failures reach the testbench checks
out=$(./obj_dir/Vspike_gen_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// ==== testbench/spike_gen_asserts.sv ====
`timescale 1ns/10ps

module spike_gen_asserts (
  input logic clk,
  input logic reset,
  input logic unit_pulse,
  input logic prog_valid,
  input logic prog_ready,
  input logic out_valid,
  input logic out_ready,
  input spike_gen_pkg::spike_event_t out_event,
  input logic overrun,
  input logic [1:0] state
);

  // failure counts, read by the testbench
  int fail_stable = 0;
  int fail_prog = 0;
  int fail_overrun = 0;

  // a stalled event holds until it is taken
  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_event))
    else begin
      fail_stable++;
      $error("spike event changed while stalled");
    end

  // an accepted entry never overlaps the start of a walk (idle is state 0)
  a_prog_idle: assert property (@(posedge clk) disable iff (reset)
    prog_valid && prog_ready |=> state == 2'd0)
    else begin
      fail_prog++;
      $error("array left idle right after taking a programming entry");
    end

  // a pulse during a walk must flag overrun
  a_overrun: assert property (@(posedge clk) disable iff (reset)
    unit_pulse && state != 2'd0 |=> overrun)
    else begin
      fail_overrun++;
      $error("overrun not set after a pulse in a busy state");
    end

endmodule

bind spike_gen_array spike_gen_asserts u_asserts (
  .clk(clk),
  .reset(reset),
  .unit_pulse(unit_pulse),
  .prog_valid(prog_valid),
  .prog_ready(prog_ready),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .out_event(out_event),
  .overrun(overrun),
  .state(state)
);

// ==== testbench/spike_gen_tb.sv ====
`timescale 1ns/10ps

module spike_gen_tb;
  import spike_gen_pkg::*;

  logic clk;
  logic reset;
  logic run;
  logic [unit_len_w-1:0] unit_len;
  logic [gens_used_w-1:0] gens_used;
  logic [n_gens-1:0] gens_en;
  logic prog_valid;
  logic prog_ready;
  gen_idx_t prog_gen_idx;
  period_t prog_ticks;
  period_t prog_period;
  tag_t prog_tag;
  logic spike_valid;
  logic spike_ready = 1'b1;
  tag_t spike_tag;
  ct_t spike_ct;
  logic unit_pulse;
  logic overrun;

  // ready pattern, 0 always high, 1 random, 2 held low
  int ready_mode;
  logic model_en;
  logic check_en;
  int spikes_seen = 0;
  int last_seen;
  // clocks counted since run rose or since the last pulse
  int pulse_gap = 0;

  // reference copy of every generator word
  period_t m_ticks [n_gens];
  period_t m_period [n_gens];
  tag_t m_tag [n_gens];
  tag_t exp_q [$];

  spike_gen_top u_spike_gen_top (
    .clk(clk), .reset(reset), .run(run), .unit_len(unit_len),
    .gens_used(gens_used), .gens_en(gens_en),
    .prog_valid(prog_valid), .prog_ready(prog_ready),
    .prog_gen_idx(prog_gen_idx), .prog_ticks(prog_ticks),
    .prog_period(prog_period), .prog_tag(prog_tag),
    .spike_valid(spike_valid), .spike_ready(spike_ready),
    .spike_tag(spike_tag), .spike_ct(spike_ct),
    .unit_pulse(unit_pulse), .overrun(overrun)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic int assert_failures();
    return u_spike_gen_top.u_array.u_asserts.fail_stable
      + u_spike_gen_top.u_array.u_asserts.fail_prog
      + u_spike_gen_top.u_array.u_asserts.fail_overrun;
  endfunction

  ////////////////////////////////////////
  // reference model

  // one time unit, generators in walk order, skip disabled or unused ones
  function automatic void model_time_unit();
    for (int g = 0; g < n_gens; g++) begin
      if (g < int'(gens_used) && gens_en[g]) begin
        if (m_ticks[g] < m_period[g]) begin
          m_ticks[g] = m_ticks[g] + 16'd1;
        end else begin
          m_ticks[g] = 16'd1;
          exp_q.push_back(m_tag[g]);
        end
      end
    end
  endfunction

  // model update, then compare on each spike handshake
  always @(posedge clk) begin : model_compare
    tag_t exp_tag;
    if (!reset && prog_valid && prog_ready) begin
      m_ticks[prog_gen_idx] = prog_ticks;
      m_period[prog_gen_idx] = prog_period;
      m_tag[prog_gen_idx] = prog_tag;
    end
    if (!reset && model_en && unit_pulse) begin
      model_time_unit();
    end
    if (!reset && check_en && spike_valid && spike_ready) begin
      assert (exp_q.size() > 0) else begin
        stop_on_error($sformatf("ERR %0t: unexpected spike tag %h", $time, spike_tag));
      end
      exp_tag = exp_q.pop_front();
      assert (spike_tag == exp_tag) else begin
        stop_on_error($sformatf("ERR %0t: tag %h, expected %h", $time, spike_tag, exp_tag));
      end
      assert (spike_ct == ct_t'(1)) else begin
        stop_on_error($sformatf("ERR %0t: count %0d, expected 1", $time, spike_ct));
      end
      spikes_seen++;
    end
  end

  // time base, one pulse every unit_len clocks while run is high
  always @(posedge clk) begin : pulse_gap_check
    if (reset || !run) begin
      pulse_gap = 0;
    end else if (unit_pulse) begin
      assert (pulse_gap == int'(unit_len)) else begin
        stop_on_error($sformatf("ERR %0t: unit_pulse after %0d clocks, expected %0d",
                                $time, pulse_gap, unit_len));
      end
      pulse_gap = 1;
    end else begin
      pulse_gap++;
    end
  end

  // back-pressure pattern
  always @(posedge clk) begin
    case (ready_mode)
      1: spike_ready <= ($urandom_range(99) >= 30);
      2: spike_ready <= 1'b0;
      default: spike_ready <= 1'b1;
    endcase
  end

  always @(negedge clk) begin
    if (assert_failures() != 0) begin
      stop_on_error("a concurrent assertion in the array failed");
    end
  end

  ////////////////////////////////////////
  // stimulus tasks

  task automatic program_gen(input int idx, input int ticks, input int period, input int tag);
    int waited = 0;
    @(posedge clk);
    prog_valid <= 1'b1;
    prog_gen_idx <= gen_idx_t'(idx);
    prog_ticks <= period_t'(ticks);
    prog_period <= period_t'(period);
    prog_tag <= tag_t'(tag);
    @(negedge clk);
    while (!prog_ready) begin
      if (waited == 100) stop_on_error("timeout waiting for prog_ready");
      waited++;
      @(negedge clk);
    end
    // taken on this edge
    @(posedge clk);
    prog_valid <= 1'b0;
  endtask

  task automatic start_run(input int len, input int used, input logic [n_gens-1:0] en);
    @(posedge clk);
    unit_len <= unit_len_w'(len);
    gens_used <= gens_used_w'(used);
    gens_en <= en;
    @(posedge clk);
    run <= 1'b1;
  endtask

  task automatic wait_units(input int n);
    int seen = 0;
    int waited = 0;
    while (seen < n) begin
      @(negedge clk);
      if (unit_pulse) seen++;
      waited++;
      if (waited > n * 1000) stop_on_error("timeout waiting for time unit pulses");
    end
  endtask

  // array idle, prog fifo empty, every expected spike delivered
  task automatic wait_quiet();
    int waited = 0;
    @(negedge clk);
    while (!(u_spike_gen_top.prog_out_ready && !u_spike_gen_top.prog_out_valid
             && exp_q.size() == 0 && !spike_valid)) begin
      if (waited == 5000) stop_on_error("timeout waiting for the array to go quiet");
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic stop_run();
    @(posedge clk);
    run <= 1'b0;
    wait_quiet();
  endtask

  task automatic check_phase(input string name);
    assert (spikes_seen > last_seen) else begin
      stop_on_error($sformatf("no spikes were seen in %s", name));
    end
    assert (overrun == 1'b0) else begin
      stop_on_error($sformatf("ERR %0t: overrun set in %s", $time, name));
    end
    last_seen = spikes_seen;
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    int waited;
    void'($urandom(82587));
    reset = 1'b1;
    run = 1'b0;
    unit_len = 16'd32;
    gens_used = '0;
    gens_en = '0;
    prog_valid = 1'b0;
    prog_gen_idx = '0;
    prog_ticks = '0;
    prog_period = '0;
    prog_tag = '0;
    ready_mode = 0;
    model_en = 1'b1;
    check_en = 1'b1;
    last_seen = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // mixed periods and start ticks
    program_gen(0, 0, 3, 'h010);
    program_gen(1, 2, 5, 'h021);
    program_gen(2, 0, 2, 'h032);
    program_gen(3, 6, 7, 'h043);
    program_gen(4, 1, 4, 'h054);
    program_gen(5, 1, 1, 'h065);
    wait_quiet();
    start_run(32, 6, 8'h3f);
    wait_units(20);
    stop_run();
    check_phase("the periodic phase");

    // generator 2 off, then only the first three in use
    start_run(32, 6, 8'h3b);
    wait_units(14);
    stop_run();
    check_phase("the enable mask phase");
    start_run(32, 3, 8'hff);
    wait_units(14);
    stop_run();
    check_phase("the gens_used phase");

    // random back-pressure
    ready_mode = 1;
    start_run(200, 6, 8'h3f);
    wait_units(30);
    stop_run();
    ready_mode = 0;
    check_phase("the back-pressure phase");

    // reprogram two generators, bring up the last two
    program_gen(1, 0, 2, 'h121);
    program_gen(4, 3, 3, 'h154);
    program_gen(6, 0, 6, 'h076);
    program_gen(7, 2, 3, 'h087);
    wait_quiet();
    start_run(60, 8, 8'hff);
    wait_units(12);
    stop_run();
    check_phase("the reprogramming phase");

    // walk longer than a time unit with the output blocked
    model_en = 1'b0;
    check_en = 1'b0;
    ready_mode = 2;
    start_run(8, 8, 8'hff);
    waited = 0;
    @(negedge clk);
    while (!overrun) begin
      if (waited == 1000) stop_on_error("timeout waiting for overrun");
      waited++;
      @(negedge clk);
    end
    repeat (40) begin
      @(negedge clk);
      assert (overrun == 1'b1) else begin
        stop_on_error($sformatf("ERR %0t: overrun dropped before reset", $time));
      end
    end
    @(posedge clk);
    run <= 1'b0;
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (overrun == 1'b0) else begin
      stop_on_error($sformatf("ERR %0t: overrun still set after reset", $time));
    end

    if (assert_failures() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_on_error("a concurrent assertion in the array failed");
    end
  end

endmodule
